/* build.f */
verilog/npa_pkg.sv
verilog/dram_region_map.sv
verilog/mesh_region_map.sv
verilog/npa_select.sv
verilog/eva_to_npa_top.sv
test/tb_clock_gen.sv
test/eva_to_npa_properties.sv
test/eva_to_npa_tb.sv

/* test/eva_to_npa_properties.sv */
// NPA selector protocol checks
// Bound to npa_select. Covers strobe timing, reset behaviour and the zero
// NPA of invalid EVAs.

`default_nettype none

module eva_to_npa_properties
  #(parameter int x_cord_width_p = 6
    , parameter int y_cord_width_p = 6
    , parameter int addr_width_p = 28
  )
  (
    input  wire logic                              clk_i
    , input  wire logic                            rst_n_i
    , input  wire logic                            req_v_i
    , input  wire logic                            npa_v_o
    , input  wire logic [x_cord_width_p-1:0]       x_cord_o
    , input  wire logic [y_cord_width_p-1:0]       y_cord_o
    , input  wire logic [addr_width_p-1:0]         epa_o
    , input  wire logic                            invalid_o
  );

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // failed assertions so far

  // strobe is the request delayed by exactly one clock
  valid_follows_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (npa_v_o == $past(req_v_i)))
    else begin
      fail_count++;
      $error("npa_v_o did not follow req_v_i by one clock");
    end

  valid_low_in_reset_a: assert property (@(posedge clk_i) !rst_n_i |=> !npa_v_o)
    else begin
      fail_count++;
      $error("npa_v_o high after a clock with reset asserted");
    end

  invalid_is_zero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (npa_v_o && invalid_o) |-> (x_cord_o == '0 && y_cord_o == '0 && epa_o == '0))
    else begin
      fail_count++;
      $error("invalid result carries a nonzero NPA");
    end

endmodule

`default_nettype wire

/* test/eva_to_npa_tb.sv */
// EVA to NPA translator testbench
// Reads the request trace, replays it twice (random gaps, then back to
// back) and checks each registered NPA against the trace columns.

`default_nettype none

module eva_to_npa_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_lines_lp = 64;
  localparam int reset_cycles_lp = 16;

  logic        clk, rst_n;
  logic        req_v, dram_enable;
  logic [31:0] eva;
  logic [5:0]  tgo_x, tgo_y;
  logic        npa_v, invalid;
  logic [5:0]  x_cord, y_cord;
  logic [27:0] epa;

  // trace columns, one entry per request
  logic [8*24-1:0] name_mem [max_lines_lp];
  logic [31:0]     stim_mem [max_lines_lp][4];  // dram, tgo_x, tgo_y, eva
  logic [31:0]     exp_mem  [max_lines_lp][4];  // x, y, epa, invalid
  int num_lines = 0;
  bit lines_loaded = 1'b0;
  int pending_q[$];  // trace index per outstanding request
  int value_errors = 0;
  int protocol_errors = 0;
  int assertion_errors = 0;
  int check_idx;

  tb_clock_gen #(.period_p(8), .reset_cycles_p(reset_cycles_lp)) u_clk (
    .clk_o(clk), .rst_n_o(rst_n));

  eva_to_npa_top #(
    .x_cord_width_p(6), .y_cord_width_p(6), .addr_width_p(28), .start_x_cord_p(0)
    , .num_tiles_x_p(4), .num_tiles_y_p(4), .vcache_block_size_in_words_p(8)
    , .vcache_size_p(1024), .vcache_sets_p(64)
  ) u_dut (
    .clk_i(clk), .rst_n_i(rst_n), .req_v_i(req_v), .eva_i(eva), .tgo_x_i(tgo_x)
    , .tgo_y_i(tgo_y), .dram_enable_i(dram_enable), .npa_v_o(npa_v)
    , .x_cord_o(x_cord), .y_cord_o(y_cord), .epa_o(epa), .invalid_o(invalid)
  );

  bind npa_select eva_to_npa_properties #(
    .x_cord_width_p(x_cord_width_p), .y_cord_width_p(y_cord_width_p)
    , .addr_width_p(addr_width_p)
  ) u_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_v_i(req_v_i)
    , .npa_v_o(npa_v_o), .x_cord_o(x_cord_o)
    , .y_cord_o(y_cord_o), .epa_o(epa_o), .invalid_o(invalid_o)
  );

  task automatic load_trace();
    int fd;
    logic [8*128-1:0] line;
    logic [8*24-1:0]  name;
    logic [31:0]      f [8];
    fd = $fopen("test/eva_to_npa_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open trace file test/eva_to_npa_trace.txt");
      protocol_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // comment and blank lines do not yield all nine fields
      if ($sscanf(line, "%s %h %h %h %h %h %h %h %h", name, f[0], f[1], f[2], f[3],
                  f[4], f[5], f[6], f[7]) == 9 && num_lines < max_lines_lp) begin
        name_mem[num_lines] = name;
        for (int k = 0; k < 4; k++) begin
          stim_mem[num_lines][k] = f[k];
          exp_mem[num_lines][k]  = f[k+4];
        end
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_request(input int idx);
    @(negedge clk);
    req_v       = 1'b1;
    dram_enable = stim_mem[idx][0][0];
    tgo_x       = stim_mem[idx][1][5:0];
    tgo_y       = stim_mem[idx][2][5:0];
    eva         = stim_mem[idx][3];
    pending_q.push_back(idx);
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n && npa_v) begin
      if (pending_q.size() == 0) begin
        $display("ERROR: result strobe at %0t with no request outstanding", $time);
        protocol_errors++;
      end else begin
        check_idx = pending_q.pop_front();
        if (x_cord !== exp_mem[check_idx][0][5:0] || y_cord !== exp_mem[check_idx][1][5:0]
            || epa !== exp_mem[check_idx][2][27:0]
            || invalid !== exp_mem[check_idx][3][0]) begin
          $display("FAILED %0s: expected x %h y %h epa %h inv %0h, actual x %h y %h epa %h inv %b",
                   name_mem[check_idx], exp_mem[check_idx][0][5:0], exp_mem[check_idx][1][5:0],
                   exp_mem[check_idx][2][27:0], exp_mem[check_idx][3], x_cord, y_cord, epa,
                   invalid);
          value_errors++;
        end
      end
    end
  end

  // run limit from trace length
  initial begin
    wait (lines_loaded);
    repeat (reset_cycles_lp + num_lines * 5 + 20) @(posedge clk);
    $display("ERROR: watchdog expired, %0d results still outstanding", pending_q.size());
    $display("Something failed");
    $finish;
  end

  initial begin
    req_v       = 1'b0;
    eva         = '0;
    tgo_x       = '0;
    tgo_y       = '0;
    dram_enable = 1'b0;
    void'($urandom(37805));
    load_trace();
    lines_loaded = 1'b1;
    @(posedge rst_n);
    // registered outputs leave reset cleared
    if (npa_v !== 1'b0 || x_cord !== '0 || y_cord !== '0 || epa !== '0
        || invalid !== 1'b0) begin
      $display("ERROR: outputs not cleared by reset");
      protocol_errors++;
    end
    for (int pass = 0; pass < 2; pass++) begin  // second pass has no gaps
      for (int i = 0; i < num_lines; i++) begin
        drive_request(i);
        if (pass == 0) begin
          repeat ($urandom % 4) begin
            @(negedge clk);
            req_v = 1'b0;
          end
        end
      end
    end
    @(negedge clk);
    req_v = 1'b0;
    repeat (3) @(negedge clk);
    if (pending_q.size() != 0) begin
      $display("ERROR: %0d requests never produced a result", pending_q.size());
      protocol_errors++;
    end
    assertion_errors = u_dut.u_select.u_props.fail_count;
    $display("checks done: %0d value errors, %0d protocol errors, %0d assertion errors over %0d requests",
             value_errors, protocol_errors, assertion_errors, 2 * num_lines);
    if (value_errors == 0 && protocol_errors == 0 && assertion_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/eva_to_npa_trace.txt */
# name dram_enable tgo_x tgo_y eva | expected x y epa invalid
# all values hex, 4x4 tiles, 8-word blocks, 1024-word banks, 64 sets
dram_bank0 1 00 00 80000000 00 00 0000000 0
dram_bank1 1 00 00 80000020 01 00 0000000 0
dram_bank2 1 00 00 80000040 02 00 0000000 0
dram_bottom_row 1 00 00 800000a4 01 05 0000001 0
dram_hash_set18 1 00 00 80001234 03 00 0000095 0
dram_hash_next_block 1 00 00 80001254 00 00 0000095 0
dram_all_ones 1 00 00 fffffffc 00 00 00001ff 0
blk_base 0 00 00 80000000 00 00 0000000 0
blk_col3_top 0 00 00 80003ffc 03 00 00003ff 0
blk_col1_bottom 0 00 00 80005008 01 05 0000002 0
host_low 0 00 00 c0000010 00 01 8000004 0
host_high 0 00 00 dffffffc 00 01 fffffff 0
global_small 0 00 00 420c0040 03 02 0000010 0
global_max 0 00 00 7ffffffc 3f 3f 000ffff 0
global_dram_on 1 00 00 450448d0 01 05 0001234 0
tg_origin0 0 00 00 21080010 02 01 0000004 0
tg_origin_3_2 0 03 02 21080010 05 03 0000004 0
tg_wrap 0 10 08 3ffeaf34 0f 27 000abcd 0
tg_origin_1_1 1 01 01 20000000 01 01 0000000 0
bad_zero 0 00 00 00000000 00 00 0000000 1
bad_low 1 00 00 1ffffffc 00 00 0000000 1
bad_mixed 0 05 05 12345678 00 00 0000000 1

/* test/tb_clock_gen.sv */
// Testbench clock and reset source
// Free running clock and an active-low reset held for a fixed number of
// rising edges, released on a falling edge.

`default_nettype none

module tb_clock_gen
  #(parameter int period_p = 8          // ns
    , parameter int reset_cycles_p = 16
  )
  (
    output logic clk_o
    , output logic rst_n_o
  );

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);  // release away from the sampling edge
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/dram_region_map.sv */
// DRAM region mapper
// With DRAM mode on, cache blocks are striped over the vcache banks above
// and below the tile array by an XOR bank hash. With DRAM mode off the
// region is plain block memory per bank, or host memory when the host
// flag is set. Purely combinational; region membership is not checked here.

`default_nettype none

module dram_region_map
  #(parameter int x_cord_width_p = 6
    , parameter int y_cord_width_p = 6
    , parameter int addr_width_p = 28
    , parameter int start_x_cord_p = 0
    , parameter int num_tiles_x_p = 4                 // power of two
    , parameter int num_tiles_y_p = 4
    , parameter int vcache_block_size_in_words_p = 8
    , parameter int vcache_size_p = 1024              // words per bank
    , parameter int vcache_sets_p = 64
  )
  (
    input  wire logic [npa_pkg::eva_width_c-1:0] eva_i  // byte addr
    , input  wire logic                          dram_enable_i
    , output logic [x_cord_width_p-1:0]          x_cord_o
    , output logic [y_cord_width_p-1:0]          y_cord_o
    , output logic [addr_width_p-1:0]            epa_o
  );

  localparam int lg_num_tiles_x_lp = $clog2(num_tiles_x_p);
  localparam int bank_width_lp = lg_num_tiles_x_lp + 1;  // {bottom, column}
  localparam int word_offset_width_lp = $clog2(vcache_block_size_in_words_p);
  localparam int set_index_width_lp = $clog2(vcache_sets_p);
  localparam int lg_vcache_size_lp = $clog2(vcache_size_p);
  // block addr spans word offset up to just below the DRAM flag
  localparam int block_lsb_lp = npa_pkg::word_addr_lsb_c + word_offset_width_lp;
  localparam int block_addr_width_lp = npa_pkg::dram_flag_bit_c - block_lsb_lp;

  localparam logic [x_cord_width_p-1:0] start_x_lp = x_cord_width_p'(start_x_cord_p);
  localparam logic [y_cord_width_p-1:0] bottom_row_lp = y_cord_width_p'(num_tiles_y_p + 1);

  logic [block_addr_width_lp-1:0]  block_addr;
  logic [word_offset_width_lp-1:0] word_offset;
  logic [bank_width_lp-1:0]        bank;
  logic [set_index_width_lp-1:0]   set_index;
  logic [lg_vcache_size_lp-1:0]    bank_offset;    // block-memory mode
  logic [lg_num_tiles_x_lp-1:0]    bank_column;    // block-memory mode
  logic                            bank_bottom;    // block-memory mode

  assign block_addr  = eva_i[block_lsb_lp +: block_addr_width_lp];
  assign word_offset = eva_i[npa_pkg::word_addr_lsb_c +: word_offset_width_lp];

  // neighbouring blocks spread over banks
  assign bank = block_addr[0 +: bank_width_lp] ^ block_addr[bank_width_lp +: bank_width_lp];
  assign set_index = block_addr[bank_width_lp +: set_index_width_lp];

  // plain word address split
  assign bank_offset = eva_i[npa_pkg::word_addr_lsb_c +: lg_vcache_size_lp];
  assign bank_column =
    eva_i[npa_pkg::word_addr_lsb_c + lg_vcache_size_lp +: lg_num_tiles_x_lp];
  assign bank_bottom = eva_i[npa_pkg::word_addr_lsb_c + lg_vcache_size_lp + lg_num_tiles_x_lp];

  always_comb begin
    if (dram_enable_i) begin
      // striped DRAM
      y_cord_o = bank[lg_num_tiles_x_lp] ? bottom_row_lp : '0;  // top bit picks the row
      x_cord_o = x_cord_width_p'(bank[0 +: lg_num_tiles_x_lp]) + start_x_lp;
      epa_o    = {{(addr_width_p - set_index_width_lp - word_offset_width_lp){1'b0}},
                  set_index, word_offset};  // msb stays clear
    end else if (eva_i[npa_pkg::host_flag_bit_c]) begin
      // host memory sits behind x 0, y 1
      y_cord_o = y_cord_width_p'(1);
      x_cord_o = '0;
      epa_o    = {1'b1, eva_i[npa_pkg::word_addr_lsb_c +: addr_width_p-1]};  // msb marks host
    end else begin
      y_cord_o = bank_bottom ? bottom_row_lp : '0;
      x_cord_o = x_cord_width_p'(bank_column) + start_x_lp;
      epa_o    = {{(addr_width_p - lg_vcache_size_lp){1'b0}}, bank_offset};
    end
  end

endmodule

`default_nettype wire

/* verilog/eva_to_npa_top.sv */
// EVA to NPA translator top level
// Sets the mesh and vcache geometry and connects the DRAM mapper and the
// mesh mapper to the selector, which registers the NPA.

`default_nettype none

module eva_to_npa_top
  #(parameter int x_cord_width_p = 6
    , parameter int y_cord_width_p = 6
    , parameter int addr_width_p = 28                 // EPA word addr width
    , parameter int start_x_cord_p = 0
    , parameter int num_tiles_x_p = 4                 // power of two
    , parameter int num_tiles_y_p = 4
    , parameter int vcache_block_size_in_words_p = 8
    , parameter int vcache_size_p = 1024              // words per bank
    , parameter int vcache_sets_p = 64
  )
  (
    input  wire logic                            clk_i
    , input  wire logic                          rst_n_i
    , input  wire logic                          req_v_i
    , input  wire logic [npa_pkg::eva_width_c-1:0] eva_i  // byte addr
    , input  wire logic [x_cord_width_p-1:0]     tgo_x_i
    , input  wire logic [y_cord_width_p-1:0]     tgo_y_i
    , input  wire logic                          dram_enable_i  // level, not per request
    , output logic                               npa_v_o
    , output logic [x_cord_width_p-1:0]          x_cord_o
    , output logic [y_cord_width_p-1:0]          y_cord_o
    , output logic [addr_width_p-1:0]            epa_o
    , output logic                               invalid_o
  );

  logic [x_cord_width_p-1:0] dram_x, global_x, tg_x;
  logic [y_cord_width_p-1:0] dram_y, global_y, tg_y;
  logic [addr_width_p-1:0]   dram_epa, global_epa, tg_epa;

  dram_region_map #(
    .x_cord_width_p               (x_cord_width_p)
    , .y_cord_width_p             (y_cord_width_p)
    , .addr_width_p               (addr_width_p)
    , .start_x_cord_p             (start_x_cord_p)
    , .num_tiles_x_p              (num_tiles_x_p)
    , .num_tiles_y_p              (num_tiles_y_p)
    , .vcache_block_size_in_words_p (vcache_block_size_in_words_p)
    , .vcache_size_p              (vcache_size_p)
    , .vcache_sets_p              (vcache_sets_p)
  ) u_dram_map (
    .eva_i          (eva_i)
    , .dram_enable_i(dram_enable_i)
    , .x_cord_o     (dram_x)
    , .y_cord_o     (dram_y)
    , .epa_o        (dram_epa)
  );

  mesh_region_map #(
    .x_cord_width_p   (x_cord_width_p)
    , .y_cord_width_p (y_cord_width_p)
    , .addr_width_p   (addr_width_p)
    , .start_x_cord_p (start_x_cord_p)
  ) u_mesh_map (
    .eva_i          (eva_i)
    , .tgo_x_i      (tgo_x_i)
    , .tgo_y_i      (tgo_y_i)
    , .global_x_o   (global_x)
    , .global_y_o   (global_y)
    , .global_epa_o (global_epa)
    , .tg_x_o       (tg_x)
    , .tg_y_o       (tg_y)
    , .tg_epa_o     (tg_epa)
  );

  npa_select #(
    .x_cord_width_p   (x_cord_width_p)
    , .y_cord_width_p (y_cord_width_p)
    , .addr_width_p   (addr_width_p)
  ) u_select (
    .clk_i          (clk_i)
    , .rst_n_i      (rst_n_i)
    , .req_v_i      (req_v_i)
    , .eva_i        (eva_i)
    , .dram_x_i     (dram_x)
    , .dram_y_i     (dram_y)
    , .dram_epa_i   (dram_epa)
    , .global_x_i   (global_x)
    , .global_y_i   (global_y)
    , .global_epa_i (global_epa)
    , .tg_x_i       (tg_x)
    , .tg_y_i       (tg_y)
    , .tg_epa_i     (tg_epa)
    , .npa_v_o      (npa_v_o)
    , .x_cord_o     (x_cord_o)
    , .y_cord_o     (y_cord_o)
    , .epa_o        (epa_o)
    , .invalid_o    (invalid_o)
  );

endmodule

`default_nettype wire

/* verilog/mesh_region_map.sv */
// Mesh region mapper
// Decodes the global and the tile-group EVA formats side by side.
// Global EVAs carry absolute coordinates; tile-group coordinates are
// relative to the tile-group origin. Combinational, no region check.

`default_nettype none

module mesh_region_map
  #(parameter int x_cord_width_p = 6
    , parameter int y_cord_width_p = 6
    , parameter int addr_width_p = 28
    , parameter int start_x_cord_p = 0
  )
  (
    input  wire logic [npa_pkg::eva_width_c-1:0] eva_i
    , input  wire logic [x_cord_width_p-1:0]     tgo_x_i  // tile-group origin
    , input  wire logic [y_cord_width_p-1:0]     tgo_y_i
    , output logic [x_cord_width_p-1:0]          global_x_o
    , output logic [y_cord_width_p-1:0]          global_y_o
    , output logic [addr_width_p-1:0]            global_epa_o
    , output logic [x_cord_width_p-1:0]          tg_x_o
    , output logic [y_cord_width_p-1:0]          tg_y_o
    , output logic [addr_width_p-1:0]            tg_epa_o
  );

  localparam logic [x_cord_width_p-1:0] start_x_lp = x_cord_width_p'(start_x_cord_p);

  logic [npa_pkg::epa_word_addr_width_c-1:0] word_addr;  // same field in both formats
  logic [addr_width_p-1:0]                   word_epa;

  assign word_addr = eva_i[npa_pkg::word_addr_lsb_c +: npa_pkg::epa_word_addr_width_c];
  assign word_epa  = {{(addr_width_p - npa_pkg::epa_word_addr_width_c){1'b0}}, word_addr};

  // absolute target
  assign global_x_o =
    x_cord_width_p'(eva_i[npa_pkg::global_x_lsb_c +: npa_pkg::global_x_width_c]);
  assign global_y_o =
    y_cord_width_p'(eva_i[npa_pkg::global_y_lsb_c +: npa_pkg::global_y_width_c]);
  assign global_epa_o = word_epa;

  // origin is kept without the start column offset, added here
  assign tg_x_o = x_cord_width_p'(eva_i[npa_pkg::tg_x_lsb_c +: npa_pkg::tg_x_width_c])
                  + tgo_x_i + start_x_lp;
  assign tg_y_o = y_cord_width_p'(eva_i[npa_pkg::tg_y_lsb_c +: npa_pkg::tg_y_width_c])
                  + tgo_y_i;
  assign tg_epa_o = word_epa;

endmodule

`default_nettype wire

/* verilog/npa_pkg.sv */
// EVA to NPA translation shared definitions
// Field positions of the global and tile-group EVA formats, the DRAM
// flag bits and the region kind produced by the classifier.

`default_nettype none

package npa_pkg;

  localparam int unsigned eva_width_c = 32;            // one word
  localparam int unsigned epa_word_addr_width_c = 16;  // word addr carried in remote EVAs
  localparam int unsigned word_addr_lsb_c = 2;         // EVA is a byte address

  // global EVA {01, y[5:0], x[5:0], addr[15:0], 00}
  localparam int unsigned global_tag_lsb_c = 30;
  localparam int unsigned global_tag_width_c = 2;
  localparam logic [global_tag_width_c-1:0] global_tag_c = 2'b01;
  localparam int unsigned global_y_lsb_c = 24;
  localparam int unsigned global_y_width_c = 6;
  localparam int unsigned global_x_lsb_c = 18;
  localparam int unsigned global_x_width_c = 6;

  // tile-group EVA {001, y[4:0], x[5:0], addr[15:0], 00}
  localparam int unsigned tg_tag_lsb_c = 29;
  localparam int unsigned tg_tag_width_c = 3;
  localparam logic [tg_tag_width_c-1:0] tg_tag_c = 3'b001;
  localparam int unsigned tg_y_lsb_c = 24;
  localparam int unsigned tg_y_width_c = 5;
  localparam int unsigned tg_x_lsb_c = 18;
  localparam int unsigned tg_x_width_c = 6;

  // DRAM region
  localparam int unsigned dram_flag_bit_c = 31;
  localparam int unsigned host_flag_bit_c = 30;  // only meaningful with DRAM mode off

  // region of an EVA, in classification priority order
  typedef enum logic [1:0] {
    EVA_DRAM       = 2'd0,
    EVA_GLOBAL     = 2'd1,
    EVA_TILE_GROUP = 2'd2,
    EVA_INVALID    = 2'd3
  } eva_kind_e;

endpackage

`default_nettype wire

/* verilog/npa_select.sv */
// NPA result selector
// Classifies the EVA (DRAM flag, then global tag, then tile-group tag),
// picks the matching mapper result, zeroes invalid ones and registers the
// NPA with its strobe one clock after the request.

`default_nettype none

module npa_select
  #(parameter int x_cord_width_p = 6
    , parameter int y_cord_width_p = 6
    , parameter int addr_width_p = 28
  )
  (
    input  wire logic                            clk_i
    , input  wire logic                          rst_n_i
    , input  wire logic                          req_v_i
    , input  wire logic [npa_pkg::eva_width_c-1:0] eva_i
    , input  wire logic [x_cord_width_p-1:0]     dram_x_i
    , input  wire logic [y_cord_width_p-1:0]     dram_y_i
    , input  wire logic [addr_width_p-1:0]       dram_epa_i
    , input  wire logic [x_cord_width_p-1:0]     global_x_i
    , input  wire logic [y_cord_width_p-1:0]     global_y_i
    , input  wire logic [addr_width_p-1:0]       global_epa_i
    , input  wire logic [x_cord_width_p-1:0]     tg_x_i
    , input  wire logic [y_cord_width_p-1:0]     tg_y_i
    , input  wire logic [addr_width_p-1:0]       tg_epa_i
    , output logic                               npa_v_o
    , output logic [x_cord_width_p-1:0]          x_cord_o
    , output logic [y_cord_width_p-1:0]          y_cord_o
    , output logic [addr_width_p-1:0]            epa_o
    , output logic                               invalid_o
  );

  npa_pkg::eva_kind_e eva_kind;
  logic [x_cord_width_p-1:0] x_n;
  logic [y_cord_width_p-1:0] y_n;
  logic [addr_width_p-1:0]   epa_n;

  // region priority
  always_comb begin
    if (eva_i[npa_pkg::dram_flag_bit_c]) begin
      eva_kind = npa_pkg::EVA_DRAM;
    end else if (eva_i[npa_pkg::global_tag_lsb_c +: npa_pkg::global_tag_width_c]
                 == npa_pkg::global_tag_c) begin
      eva_kind = npa_pkg::EVA_GLOBAL;
    end else if (eva_i[npa_pkg::tg_tag_lsb_c +: npa_pkg::tg_tag_width_c]
                 == npa_pkg::tg_tag_c) begin
      eva_kind = npa_pkg::EVA_TILE_GROUP;
    end else begin
      eva_kind = npa_pkg::EVA_INVALID;
    end
  end

  always_comb begin
    unique case (eva_kind)
      npa_pkg::EVA_DRAM:       {x_n, y_n, epa_n} = {dram_x_i, dram_y_i, dram_epa_i};
      npa_pkg::EVA_GLOBAL:     {x_n, y_n, epa_n} = {global_x_i, global_y_i, global_epa_i};
      npa_pkg::EVA_TILE_GROUP: {x_n, y_n, epa_n} = {tg_x_i, tg_y_i, tg_epa_i};
      default:                 {x_n, y_n, epa_n} = '0;  // no region, all-zero NPA
    endcase
  end

  // one register stage, data held between requests
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      npa_v_o   <= 1'b0;
      x_cord_o  <= '0;
      y_cord_o  <= '0;
      epa_o     <= '0;
      invalid_o <= 1'b0;
    end else begin
      npa_v_o <= req_v_i;  // no back-pressure
      if (req_v_i) begin
        x_cord_o  <= x_n;
        y_cord_o  <= y_n;
        epa_o     <= epa_n;
        invalid_o <= (eva_kind == npa_pkg::EVA_INVALID);
      end
    end
  end

endmodule

`default_nettype wire
